/* project.f */
logic/soc_pkg.sv
logic/mem_req_if.sv
logic/axi_master_arbiter.sv
logic/icache.sv
logic/data_port.sv
logic/soc_mem.sv
verification/soc_mem_assert.sv
verification/tb_soc_mem.sv

/* verification/tb_soc_mem.sv */
module tb_soc_mem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] seed      = 32'hdd67_b379;
  localparam logic [3:0]  fetch_id  = 4'd0;
  localparam logic [3:0]  data_id   = 4'd1;
  localparam int          mem_words = 1024;  // 8 KB behind the axi port
  localparam int          wait_max  = 200;

  logic clock;
  logic arst_n;
  logic fetch_req, fetch_busy, fetch_valid;
  logic [soc_pkg::addr_w-1:0] fetch_addr;
  logic [soc_pkg::data_w-1:0] fetch_data;
  logic data_req, data_we, data_busy, data_done;
  logic [soc_pkg::addr_w-1:0] data_addr;
  logic [soc_pkg::data_w-1:0] data_wdata, data_rdata;
  logic [soc_pkg::strb_w-1:0] data_wstrb;
  logic axi_arready, axi_arvalid, axi_rready, axi_rvalid, axi_rlast;
  logic axi_awready, axi_awvalid, axi_wready, axi_wvalid, axi_wlast;
  logic axi_bready, axi_bvalid;
  logic [soc_pkg::addr_w-1:0] axi_araddr, axi_awaddr;
  logic [soc_pkg::id_w-1:0]   axi_arid, axi_rid, axi_awid, axi_bid;
  logic [7:0] axi_arlen, axi_awlen;
  logic [2:0] axi_arsize, axi_awsize;
  logic [1:0] axi_arburst, axi_awburst, axi_rresp, axi_bresp;
  logic [soc_pkg::data_w-1:0] axi_rdata, axi_wdata;
  logic [soc_pkg::strb_w-1:0] axi_wstrb;
  logic [soc_pkg::sram_aw-1:0] sram_addr;
  logic sram_cen, sram_wen;
  logic [soc_pkg::line_w-1:0] sram_wmask, sram_wdata;
  logic [soc_pkg::line_w-1:0] sram_rdata = '0;

  logic [63:0]  axi_mem [mem_words];  // slave model storage
  logic [63:0]  shadow [mem_words];   // expected contents
  logic [127:0] sram_mem [64];
  logic [31:0]  axi_rng;
  logic [31:0]  stim_rng;
  int errors = 0;
  int tests_ok = 0;
  int tests_bad = 0;
  int cyc = 0;
  logic f_pend = 1'b0;
  logic d_pend = 1'b0;
  logic d_load;
  logic [63:0] f_exp, d_exp;
  int f_t0, f_lat, f_skip, d_skip;
  int ar_count = 0;
  logic [31:0] last_araddr;
  logic [7:0]  last_arlen;
  logic [3:0]  last_arid;

  soc_mem #(
    .fetch_id    (fetch_id),
    .data_id     (data_id),
    .icache_sets (64)
  ) i_dut (.*);

  bind soc_mem soc_mem_assert i_assert (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_axi();
    axi_rng = xorshift(axi_rng);
    return axi_rng;
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] wd,
                                              input logic [7:0] st);
    logic [63:0] r;
    r = old;
    for (int b = 0; b < soc_pkg::strb_w; b++) begin
      if (st[b]) r[b*8 +: 8] = wd[b*8 +: 8];
    end
    return r;
  endfunction

  // expected word at a byte address
  function automatic logic [63:0] ref_word(input logic [31:0] addr);
    return shadow[addr[12:3]];
  endfunction

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int base);
    if (errors == base) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: failed with %0d errors", name, errors - base);
    end
  endtask

  task automatic give_up(input string what);
    $display("timeout: %s", what);
    $display("sim failed");
    $finish;
  endtask

  task automatic fetch_start(input logic [31:0] addr);
    fetch_req  = 1'b1;
    fetch_addr = addr;
    f_exp      = ref_word(addr);
    f_pend     = 1'b1;
    f_t0       = cyc;
    f_skip     = 0;
  endtask

  task automatic data_start(input logic we, input logic [31:0] addr, input logic [63:0] wd,
                            input logic [7:0] st);
    data_req   = 1'b1;
    data_we    = we;
    data_addr  = addr;
    data_wdata = wd;
    data_wstrb = st;
    d_pend     = 1'b1;
    d_load     = !we;
    d_skip     = 0;
    if (we) shadow[addr[12:3]] = merge_bytes(shadow[addr[12:3]], wd, st);
    else d_exp = ref_word(addr);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while ((f_pend || d_pend || fetch_busy || data_busy) && n < wait_max) begin
      @(negedge clock);
      fetch_req = 1'b0;
      data_req  = 1'b0;
      n++;
    end
    if (f_pend || d_pend || fetch_busy || data_busy) give_up("a fetch or data access never completed");
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // line sram, one cycle read, mask bit 0 writes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clock) begin
    if (!sram_cen) begin
      if (!sram_wen) begin
        sram_mem[sram_addr] <= (sram_mem[sram_addr] & sram_wmask) | (sram_wdata & ~sram_wmask);
      end else begin
        sram_rdata <= sram_mem[sram_addr];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi slave, handshakes taken on rise, drives on fall
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
    logic rd_busy, aw_got, w_got;
    logic [9:0] rd_idx, wr_idx;
    logic [7:0] rd_beat, rd_len;
    logic [3:0] rd_id, wr_id;
    logic [63:0] wr_data;
    logic [7:0] wr_strb;
    int ar_wait, r_wait, aw_wait, w_wait, b_wait;
    axi_rng = seed;
    {axi_arready, axi_rvalid, axi_rlast, axi_awready, axi_wready, axi_bvalid} = '0;
    axi_rresp = soc_pkg::axi_resp_okay;
    axi_bresp = soc_pkg::axi_resp_okay;
    axi_rdata = '0;
    axi_rid   = '0;
    axi_bid   = '0;
    {rd_busy, aw_got, w_got} = '0;
    ar_wait = next_axi() % 4;
    aw_wait = next_axi() % 4;
    w_wait  = next_axi() % 4;
    b_wait  = next_axi() % 4;
    forever begin
      @(posedge clock);
      ar_hs = axi_arvalid && axi_arready;
      r_hs  = axi_rvalid && axi_rready;
      aw_hs = axi_awvalid && axi_awready;
      w_hs  = axi_wvalid && axi_wready;
      b_hs  = axi_bvalid && axi_bready;
      if (ar_hs) begin
        rd_busy = 1'b1;
        rd_idx  = axi_araddr[12:3];
        rd_len  = axi_arlen;
        rd_id   = axi_arid;
        rd_beat = '0;
        r_wait  = next_axi() % 4;
      end
      if (r_hs) begin
        rd_idx++;
        rd_beat++;
      end
      if (aw_hs) begin
        aw_got = 1'b1;
        wr_idx = axi_awaddr[12:3];
        wr_id  = axi_awid;
      end
      if (w_hs) begin
        w_got   = 1'b1;
        wr_data = axi_wdata;
        wr_strb = axi_wstrb;
      end
      @(negedge clock);
      if (ar_hs) begin
        axi_arready = 1'b0;
        ar_wait = next_axi() % 4;
      end
      if (!rd_busy && axi_arvalid && !axi_arready) begin
        if (ar_wait == 0) axi_arready = 1'b1;
        else ar_wait--;
      end
      if (r_hs) begin
        axi_rvalid = 1'b0;
        r_wait = next_axi() % 4;
        if (rd_beat > rd_len) rd_busy = 1'b0;
      end
      if (rd_busy && !axi_rvalid) begin
        if (r_wait == 0) begin
          axi_rvalid = 1'b1;
          axi_rdata  = axi_mem[rd_idx];
          axi_rlast  = (rd_beat == rd_len);
          axi_rid    = rd_id;
        end else begin
          r_wait--;
        end
      end
      if (aw_hs) axi_awready = 1'b0;
      if (w_hs) axi_wready = 1'b0;
      if (axi_awvalid && !aw_got && !axi_awready) begin
        if (aw_wait == 0) axi_awready = 1'b1;
        else aw_wait--;
      end
      if (axi_wvalid && !w_got && !axi_wready) begin
        if (w_wait == 0) axi_wready = 1'b1;
        else w_wait--;
      end
      if (b_hs) begin
        axi_bvalid = 1'b0;
        {aw_got, w_got} = '0;
        aw_wait = next_axi() % 4;
        w_wait  = next_axi() % 4;
        b_wait  = next_axi() % 4;
      end else if (aw_got && w_got && !axi_bvalid) begin
        if (b_wait == 0) begin
          axi_mem[wr_idx] = merge_bytes(axi_mem[wr_idx], wr_data, wr_strb);
          axi_bvalid = 1'b1;
          axi_bid    = wr_id;
        end else begin
          b_wait--;
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare responses, count bursts and grants
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clock) begin
    logic [3:0] addr_id;
    cyc++;
    if (arst_n) begin
      if (fetch_valid) begin
        if (!f_pend) begin
          errors++;
          $display("fetch_valid arrived at %0t with no fetch outstanding", $time);
        end
        check_val("fetch_data", fetch_data, f_exp);
        f_lat  = cyc - f_t0 - 1;  // cycles after the request cycle
        f_pend = 1'b0;
      end
      if (data_done) begin
        if (!d_pend) begin
          errors++;
          $display("data_done arrived at %0t with no access outstanding", $time);
        end
        if (d_load) check_val("data_rdata", data_rdata, d_exp);
        d_pend = 1'b0;
      end
      if (!sram_cen && !sram_wen) check_val("sram_wmask", sram_wmask, 0);  // full line write
      if (axi_arvalid && axi_arready) begin
        ar_count++;
        last_araddr = axi_araddr;
        last_arlen  = axi_arlen;
        last_arid   = axi_arid;
        check_val("axi_arsize", axi_arsize, 3);  // 8 byte beats
        check_val("axi_arburst", axi_arburst, 1);  // incr
      end
      if (axi_awvalid && axi_awready) begin
        check_val("axi_awlen", axi_awlen, 0);
        check_val("axi_awsize", axi_awsize, 3);
        check_val("axi_awburst", axi_awburst, 1);
      end
      if (axi_wvalid && axi_wready) check_val("axi_wlast", axi_wlast, 1);
      if ((axi_arvalid && axi_arready) || (axi_awvalid && axi_awready)) begin
        addr_id = axi_arvalid ? axi_arid : axi_awid;
        if (addr_id == fetch_id) begin
          f_skip = 0;
          if (d_pend) d_skip++;
        end else begin
          d_skip = 0;
          if (f_pend) f_skip++;
        end
        if (f_skip >= 2 || d_skip >= 2) begin
          errors++;
          $display("a port waited through two grants of the other at %0t", $time);
        end
      end
    end
  end

  initial begin
    int base;
    int ar0;
    int nf;
    int nd;
    int n;
    logic [31:0] r;
    logic [31:0] addr_list [8];
    logic [31:0] conflict [4];
    stim_rng = xorshift(~seed);
    conflict = '{32'h048, 32'h448, 32'h048, 32'h448};  // index 4, tags 0 and 1
    for (int i = 0; i < mem_words; i++) begin
      axi_mem[i] = {xorshift(seed ^ i), xorshift(~seed ^ (i << 10))};
      shadow[i]  = axi_mem[i];
    end
    {fetch_req, data_req, data_we} = '0;
    fetch_addr = '0;
    data_addr  = '0;
    data_wdata = '0;
    data_wstrb = '0;
    arst_n = 1'b0;
    repeat (5) @(negedge clock);
    arst_n = 1'b1;
    @(negedge clock);

    base = errors;
    check_val("fetch_busy", fetch_busy, 0);
    check_val("fetch_valid", fetch_valid, 0);
    check_val("data_busy", data_busy, 0);
    check_val("data_done", data_done, 0);
    check_val("axi_arvalid", axi_arvalid, 0);
    check_val("axi_awvalid", axi_awvalid, 0);
    check_val("axi_wvalid", axi_wvalid, 0);
    check_val("axi_rready", axi_rready, 0);
    check_val("axi_bready", axi_bready, 0);
    check_val("sram_cen", sram_cen, 1);
    finish_test("reset state", base);

    base = errors;
    ar0  = ar_count;
    fetch_start(32'h100);
    wait_idle();
    check_val("ar burst count", ar_count, ar0 + 1);
    check_val("axi_arlen", last_arlen, 1);
    check_val("axi_arid", last_arid, fetch_id);
    check_val("axi_araddr", last_araddr, 32'h100);
    finish_test("fetch miss", base);

    base = errors;
    fetch_start(32'h108);
    wait_idle();
    check_val("hit latency", f_lat, 1);
    fetch_start(32'h100);
    wait_idle();
    check_val("hit latency", f_lat, 1);
    check_val("ar burst count", ar_count, ar0 + 1);
    finish_test("fetch hit", base);

    base = errors;
    for (int i = 0; i < 4; i++) begin
      ar0 = ar_count;
      fetch_start(conflict[i]);
      wait_idle();
      check_val("ar burst count", ar_count, ar0 + 1);
    end
    finish_test("line replacement", base);

    base = errors;
    for (int i = 0; i < 8; i++) begin
      r = next_stim();
      addr_list[i] = 32'h1000 | {23'd0, r[8:3], 3'd0};
      data_start(1'b1, addr_list[i], {next_stim(), next_stim()}, r[23:16]);
      wait_idle();
    end
    for (int i = 0; i < 8; i++) begin
      data_start(1'b0, addr_list[i], '0, '0);
      wait_idle();
    end
    finish_test("strobed stores", base);

    base = errors;
    nf = 0;
    nd = 0;
    n  = 0;
    while ((nf < 24 || nd < 24) && n < 3000) begin
      @(negedge clock);
      fetch_req = 1'b0;
      data_req  = 1'b0;
      r = next_stim();
      if (nf < 24 && !f_pend && !fetch_busy && r[1:0] != 2'd0) begin
        fetch_start({21'd0, r[10:3], 3'd0});  // 2 KB window, two tags per index
        nf++;
      end
      if (nd < 24 && !d_pend && !data_busy && r[17:16] != 2'd0) begin
        data_start(r[18], 32'h1000 | {23'd0, r[25:20], 3'd0}, {next_stim(), next_stim()},
                   r[31:24]);
        nd++;
      end
      n++;
    end
    if (nf < 24 || nd < 24) give_up("random traffic could not be issued");
    wait_idle();
    finish_test("concurrent traffic", base);

    $display("tests: %0d ok, %0d failed, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* verification/soc_mem_assert.sv */
module soc_mem_assert (
  input logic                       clock,
  input logic                       arst_n,
  input logic                       fetch_req,
  input logic                       fetch_busy,
  input logic                       fetch_valid,
  input logic                       data_req,
  input logic                       data_busy,
  input logic                       data_done,
  input logic                       axi_arvalid,
  input logic                       axi_arready,
  input logic [soc_pkg::addr_w-1:0] axi_araddr,
  input logic [7:0]                 axi_arlen,
  input logic [soc_pkg::id_w-1:0]   axi_arid,
  input logic                       axi_awvalid,
  input logic                       axi_awready,
  input logic [soc_pkg::addr_w-1:0] axi_awaddr,
  input logic [soc_pkg::id_w-1:0]   axi_awid,
  input logic                       axi_wvalid,
  input logic                       axi_wready,
  input logic [soc_pkg::data_w-1:0] axi_wdata,
  input logic [soc_pkg::strb_w-1:0] axi_wstrb
);
  timeunit 1ns;
  timeprecision 1ps;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core side strobes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_fetch_idle: assert property (@(posedge clock) disable iff (!arst_n)
    fetch_req |-> !fetch_busy) else $error("fetch request while the fetch port is busy");
  a_data_idle: assert property (@(posedge clock) disable iff (!arst_n)
    data_req |-> !data_busy) else $error("data request while the data port is busy");
  a_fetch_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    fetch_valid |=> !fetch_valid) else $error("fetch_valid longer than one cycle");
  a_done_pulse: assert property (@(posedge clock) disable iff (!arst_n)
    data_done |=> !data_done) else $error("data_done longer than one cycle");

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi valid and payload hold under back-pressure
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  a_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr) &&
    $stable(axi_arlen) && $stable(axi_arid)) else $error("ar channel changed while stalled");
  a_aw_hold: assert property (@(posedge clock) disable iff (!arst_n)
    axi_awvalid && !axi_awready |=> axi_awvalid && $stable(axi_awaddr) &&
    $stable(axi_awid)) else $error("aw channel changed while stalled");
  a_w_hold: assert property (@(posedge clock) disable iff (!arst_n)
    axi_wvalid && !axi_wready |=> axi_wvalid && $stable(axi_wdata) &&
    $stable(axi_wstrb)) else $error("w channel changed while stalled");

endmodule

/* logic/soc_mem.sv */
module soc_mem #(
  parameter logic [soc_pkg::id_w-1:0] fetch_id    = 4'd0,
  parameter logic [soc_pkg::id_w-1:0] data_id     = 4'd1,
  parameter int unsigned              icache_sets = 64
) (
  input  logic                        clock,
  input  logic                        arst_n,
  // instruction fetch
  input  logic                        fetch_req,
  input  logic [soc_pkg::addr_w-1:0]  fetch_addr,
  output logic                        fetch_busy,
  output logic                        fetch_valid,
  output logic [soc_pkg::data_w-1:0]  fetch_data,
  // uncached data
  input  logic                        data_req,
  input  logic                        data_we,
  input  logic [soc_pkg::addr_w-1:0]  data_addr,
  input  logic [soc_pkg::data_w-1:0]  data_wdata,
  input  logic [soc_pkg::strb_w-1:0]  data_wstrb,
  output logic                        data_busy,
  output logic                        data_done,
  output logic [soc_pkg::data_w-1:0]  data_rdata,
  // axi4 master
  input  logic                        axi_arready,
  output logic                        axi_arvalid,
  output logic [soc_pkg::addr_w-1:0]  axi_araddr,
  output logic [soc_pkg::id_w-1:0]    axi_arid,
  output logic [7:0]                  axi_arlen,
  output logic [2:0]                  axi_arsize,
  output logic [1:0]                  axi_arburst,
  output logic                        axi_rready,
  input  logic                        axi_rvalid,
  input  logic [1:0]                  axi_rresp,
  input  logic [soc_pkg::data_w-1:0]  axi_rdata,
  input  logic                        axi_rlast,
  input  logic [soc_pkg::id_w-1:0]    axi_rid,
  input  logic                        axi_awready,
  output logic                        axi_awvalid,
  output logic [soc_pkg::addr_w-1:0]  axi_awaddr,
  output logic [soc_pkg::id_w-1:0]    axi_awid,
  output logic [7:0]                  axi_awlen,
  output logic [2:0]                  axi_awsize,
  output logic [1:0]                  axi_awburst,
  input  logic                        axi_wready,
  output logic                        axi_wvalid,
  output logic [soc_pkg::data_w-1:0]  axi_wdata,
  output logic [soc_pkg::strb_w-1:0]  axi_wstrb,
  output logic                        axi_wlast,
  output logic                        axi_bready,
  input  logic                        axi_bvalid,
  input  logic [1:0]                  axi_bresp,
  input  logic [soc_pkg::id_w-1:0]    axi_bid,
  // icache line sram
  output logic [soc_pkg::sram_aw-1:0] sram_addr,
  output logic                        sram_cen,
  output logic                        sram_wen,
  output logic [soc_pkg::line_w-1:0]  sram_wmask,
  output logic [soc_pkg::line_w-1:0]  sram_wdata,
  input  logic [soc_pkg::line_w-1:0]  sram_rdata
);

  mem_req_if fetch_bus ();
  mem_req_if data_bus ();

  icache #(
    .icache_sets (icache_sets)
  ) i_icache (
    .bus (fetch_bus),
    .*
  );

  data_port i_data_port (
    .bus (data_bus),
    .*
  );

  axi_master_arbiter #(
    .fetch_id (fetch_id),
    .data_id  (data_id)
  ) i_arbiter (
    .fetch (fetch_bus),
    .data  (data_bus),
    .*
  );

endmodule

/* logic/data_port.sv */
module data_port (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       data_req,
  input  logic                       data_we,
  input  logic [soc_pkg::addr_w-1:0] data_addr,
  input  logic [soc_pkg::data_w-1:0] data_wdata,
  input  logic [soc_pkg::strb_w-1:0] data_wstrb,
  output logic                       data_busy,
  output logic                       data_done,
  output logic [soc_pkg::data_w-1:0] data_rdata,
  mem_req_if.requester               bus
);

  logic                       req_q;
  logic                       we_q;
  logic [soc_pkg::addr_w-1:0] addr_q;
  logic [soc_pkg::data_w-1:0] wdata_q;
  logic [soc_pkg::strb_w-1:0] wstrb_q;
  logic [soc_pkg::data_w-1:0] rdata_q;

  logic accept;

  assign accept = data_req && !req_q;

  assign bus.req   = req_q;
  assign bus.write = we_q;
  assign bus.addr  = addr_q;
  assign bus.len   = 8'd0;  // single beat
  assign bus.wdata = wdata_q;
  assign bus.wstrb = wstrb_q;

  assign data_busy  = req_q;     // covers the done cycle too
  assign data_done  = bus.done;
  assign data_rdata = rdata_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      req_q <= 1'b0;
    end else if (accept) begin
      req_q <= 1'b1;
    end else if (bus.done) begin
      req_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      we_q    <= data_we;
      addr_q  <= data_addr;
      wdata_q <= data_wdata;
      wstrb_q <= data_wstrb;
    end
    if (bus.gnt && bus.rvalid && !we_q) rdata_q <= bus.rdata;  // load beat
  end

endmodule

/* logic/icache.sv */
module icache #(
  parameter int unsigned icache_sets = 64
) (
  input  logic                       clock,
  input  logic                       arst_n,
  input  logic                       fetch_req,
  input  logic [soc_pkg::addr_w-1:0] fetch_addr,
  output logic                       fetch_busy,
  output logic                       fetch_valid,
  output logic [soc_pkg::data_w-1:0] fetch_data,
  mem_req_if.requester               bus,
  output logic [soc_pkg::sram_aw-1:0] sram_addr,
  output logic                       sram_cen,
  output logic                       sram_wen,
  output logic [soc_pkg::line_w-1:0] sram_wmask,
  output logic [soc_pkg::line_w-1:0] sram_wdata,
  input  logic [soc_pkg::line_w-1:0] sram_rdata
);

  localparam int unsigned idx_w  = $clog2(icache_sets);
  localparam int unsigned off_w  = $clog2(soc_pkg::line_w / 8);  // byte offset in a line
  localparam int unsigned byte_w = $clog2(soc_pkg::data_w / 8);  // byte offset in a word
  localparam int unsigned beat_w = $clog2(soc_pkg::line_beats);
  localparam int unsigned tag_w  = soc_pkg::addr_w - idx_w - off_w;

  typedef enum logic [1:0] {st_idle, st_hit, st_miss, st_resp} state_t;

  state_t                     state_q;
  logic [icache_sets-1:0]     valid_q;
  logic [tag_w-1:0]           tag_mem [icache_sets];
  logic                       req_q;
  logic [beat_w-1:0]          beat_q;   // next refill beat
  logic [idx_w-1:0]           idx_q;
  logic [tag_w-1:0]           tag_q;
  logic [beat_w-1:0]          word_q;
  logic [soc_pkg::line_w-1:0] line_q;

  logic [idx_w-1:0] req_idx;
  logic [tag_w-1:0] req_tag;
  logic             lookup;
  logic             hit;
  logic             beat_in;
  logic             fill;

  assign req_idx = fetch_addr[off_w +: idx_w];
  assign req_tag = fetch_addr[soc_pkg::addr_w-1 -: tag_w];
  assign lookup  = (state_q == st_idle) && fetch_req;
  assign hit     = valid_q[req_idx] && (tag_mem[req_idx] == req_tag);
  assign beat_in = (state_q == st_miss) && bus.gnt && bus.rvalid;
  assign fill    = (state_q == st_miss) && bus.done;  // cycle after rlast

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sram port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign sram_cen   = !(lookup || fill);
  assign sram_wen   = !fill;
  assign sram_addr  = fill ? idx_q : req_idx;
  assign sram_wmask = '0;  // whole line
  assign sram_wdata = line_q;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // core side
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign fetch_busy  = state_q != st_idle;
  assign fetch_valid = (state_q == st_hit) || (state_q == st_resp);
  assign fetch_data  = (state_q == st_resp) ?
                       line_q[word_q*soc_pkg::data_w +: soc_pkg::data_w] :
                       sram_rdata[word_q*soc_pkg::data_w +: soc_pkg::data_w];

  // refill request, one aligned line
  assign bus.req   = req_q;
  assign bus.write = 1'b0;
  assign bus.addr  = {tag_q, idx_q, {off_w{1'b0}}};
  assign bus.len   = 8'(soc_pkg::line_beats - 1);
  assign bus.wdata = '0;
  assign bus.wstrb = '0;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      valid_q <= '0;
      req_q   <= 1'b0;
      beat_q  <= '0;
    end else begin
      case (state_q)
        st_idle: begin
          if (fetch_req) begin
            if (hit) begin
              state_q <= st_hit;
            end else begin
              state_q <= st_miss;
              req_q   <= 1'b1;
            end
          end
        end
        st_hit: state_q <= st_idle;
        st_miss: begin
          if (beat_in) beat_q <= bus.rlast ? '0 : beat_q + 1'b1;
          if (bus.done) begin
            req_q          <= 1'b0;
            valid_q[idx_q] <= 1'b1;
            state_q        <= st_resp;
          end
        end
        st_resp: state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (lookup) begin
      idx_q  <= req_idx;
      tag_q  <= req_tag;
      word_q <= fetch_addr[byte_w +: beat_w];
    end
    if (beat_in) line_q[beat_q*soc_pkg::data_w +: soc_pkg::data_w] <= bus.rdata;
    if (fill) tag_mem[idx_q] <= tag_q;
  end

endmodule

/* logic/axi_master_arbiter.sv */
module axi_master_arbiter #(
  parameter logic [soc_pkg::id_w-1:0] fetch_id = 4'd0,
  parameter logic [soc_pkg::id_w-1:0] data_id  = 4'd1
) (
  input  logic                       clock,
  input  logic                       arst_n,
  mem_req_if.arbiter                 fetch,
  mem_req_if.arbiter                 data,
  input  logic                       axi_arready,
  output logic                       axi_arvalid,
  output logic [soc_pkg::addr_w-1:0] axi_araddr,
  output logic [soc_pkg::id_w-1:0]   axi_arid,
  output logic [7:0]                 axi_arlen,
  output logic [2:0]                 axi_arsize,
  output logic [1:0]                 axi_arburst,
  output logic                       axi_rready,
  input  logic                       axi_rvalid,
  input  logic [1:0]                 axi_rresp,
  input  logic [soc_pkg::data_w-1:0] axi_rdata,
  input  logic                       axi_rlast,
  input  logic [soc_pkg::id_w-1:0]   axi_rid,
  input  logic                       axi_awready,
  output logic                       axi_awvalid,
  output logic [soc_pkg::addr_w-1:0] axi_awaddr,
  output logic [soc_pkg::id_w-1:0]   axi_awid,
  output logic [7:0]                 axi_awlen,
  output logic [2:0]                 axi_awsize,
  output logic [1:0]                 axi_awburst,
  input  logic                       axi_wready,
  output logic                       axi_wvalid,
  output logic [soc_pkg::data_w-1:0] axi_wdata,
  output logic [soc_pkg::strb_w-1:0] axi_wstrb,
  output logic                       axi_wlast,
  output logic                       axi_bready,
  input  logic                       axi_bvalid,
  input  logic [1:0]                 axi_bresp,
  input  logic [soc_pkg::id_w-1:0]   axi_bid
);

  typedef enum logic [1:0] {st_idle, st_addr, st_data, st_resp} state_t;

  state_t state_q;
  logic   data_last_q;  // data port owns the bus, or was served last
  logic   aw_done_q;
  logic   w_done_q;
  logic   err_q;        // bad beat seen earlier in this burst

  logic                       pick_data;
  logic                       sel_write;
  logic [soc_pkg::addr_w-1:0] sel_addr;
  logic [7:0]                 sel_len;
  logic [soc_pkg::id_w-1:0]   cur_id;
  logic                       aw_ok;
  logic                       w_ok;
  logic                       r_beat;
  logic                       r_err;
  logic                       b_beat;
  logic                       b_err;

  assign pick_data = data.req && (!fetch.req || !data_last_q);  // round robin on a tie

  assign sel_write = data_last_q ? data.write : fetch.write;
  assign sel_addr  = data_last_q ? data.addr  : fetch.addr;
  assign sel_len   = data_last_q ? data.len   : fetch.len;
  assign cur_id    = data_last_q ? data_id    : fetch_id;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi channels, payload held by the owner's req
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign axi_arvalid = (state_q == st_addr) && !sel_write;
  assign axi_araddr  = sel_addr;
  assign axi_arid    = cur_id;
  assign axi_arlen   = sel_len;
  assign axi_arsize  = soc_pkg::axi_size_8b;
  assign axi_arburst = soc_pkg::axi_burst_incr;
  assign axi_rready  = (state_q == st_data) && !sel_write;

  assign axi_awvalid = (state_q == st_addr) && sel_write && !aw_done_q;
  assign axi_awaddr  = sel_addr;
  assign axi_awid    = cur_id;
  assign axi_awlen   = sel_len;
  assign axi_awsize  = soc_pkg::axi_size_8b;
  assign axi_awburst = soc_pkg::axi_burst_incr;

  assign axi_wvalid  = (state_q == st_addr) && sel_write && !w_done_q;
  assign axi_wdata   = data_last_q ? data.wdata : fetch.wdata;
  assign axi_wstrb   = data_last_q ? data.wstrb : fetch.wstrb;
  assign axi_wlast   = 1'b1;  // writes are single beat
  assign axi_bready  = (state_q == st_data) && sel_write;

  assign aw_ok  = aw_done_q || axi_awready;
  assign w_ok   = w_done_q || axi_wready;
  assign r_beat = axi_rvalid && axi_rready;
  assign r_err  = (axi_rresp != soc_pkg::axi_resp_okay) || (axi_rid != cur_id);
  assign b_beat = axi_bvalid && axi_bready;
  assign b_err  = (axi_bresp != soc_pkg::axi_resp_okay) || (axi_bid != cur_id);

  // return path to the owner
  assign fetch.gnt    = (state_q != st_idle) && !data_last_q;
  assign fetch.rvalid = r_beat && !data_last_q;
  assign fetch.rdata  = axi_rdata;
  assign fetch.rlast  = axi_rlast;
  assign fetch.done   = (state_q == st_resp) && !data_last_q;

  assign data.gnt     = (state_q != st_idle) && data_last_q;
  assign data.rvalid  = r_beat && data_last_q;
  assign data.rdata   = axi_rdata;
  assign data.rlast   = axi_rlast;
  assign data.done    = (state_q == st_resp) && data_last_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      state_q     <= st_idle;
      data_last_q <= 1'b0;
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      err_q       <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (fetch.req || data.req) begin
            data_last_q <= pick_data;
            state_q     <= st_addr;
          end
        end
        st_addr: begin
          if (sel_write) begin
            aw_done_q <= aw_ok && !w_ok;
            w_done_q  <= w_ok && !aw_ok;
            if (aw_ok && w_ok) state_q <= st_data;
          end else if (axi_arready) begin
            state_q <= st_data;
          end
        end
        st_data: begin
          if (sel_write) begin
            if (b_beat) state_q <= b_err ? st_addr : st_resp;  // slave error, reissue
          end else if (r_beat) begin
            err_q <= axi_rlast ? 1'b0 : (err_q || r_err);
            if (axi_rlast) state_q <= (err_q || r_err) ? st_addr : st_resp;
          end
        end
        st_resp: state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

endmodule

/* logic/mem_req_if.sv */
interface mem_req_if;

  // requester side
  logic                          req;    // held until done
  logic                          write;
  logic [soc_pkg::addr_w-1:0]    addr;
  logic [7:0]                    len;    // axi encoding, beats minus one
  logic [soc_pkg::data_w-1:0]    wdata;
  logic [soc_pkg::strb_w-1:0]    wstrb;

  // arbiter side
  logic                          gnt;    // level while this port owns the bus
  logic                          rvalid; // one pulse per read beat
  logic [soc_pkg::data_w-1:0]    rdata;
  logic                          rlast;
  logic                          done;   // end of the transaction

  modport requester (
    output req, write, addr, len, wdata, wstrb,
    input  gnt, rvalid, rdata, rlast, done
  );

  modport arbiter (
    input  req, write, addr, len, wdata, wstrb,
    output gnt, rvalid, rdata, rlast, done
  );

endinterface

/* logic/soc_pkg.sv */
package soc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // bus widths
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned addr_w = 32;
  localparam int unsigned data_w = 64;   // one axi beat, one fetch or data word
  localparam int unsigned strb_w = 8;
  localparam int unsigned id_w   = 4;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // axi4 encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam logic [1:0] axi_burst_incr = 2'b01;
  localparam logic [2:0] axi_size_8b    = 3'b011;
  localparam logic [1:0] axi_resp_okay  = 2'b00;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // sram macro and cache line geometry
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int unsigned line_w     = 128;  // also the sram word
  localparam int unsigned sram_aw    = 6;    // 64 lines
  localparam int unsigned line_beats = 2;    // line_w / data_w

endpackage
